// ==== tests/fetch_patterns.txt ====
// Words 000-07f: memory image from 0x80000000. Word 080: number of flushes,
// then pairs of (accepted count, flush target). Word 0ff: expected accepted total.
@000
00108093
00208093
00000463
00308093
00110113
00118193
fe209ce3
@008
00708093
0000006f
@040
00408093
0140006f
@046
00528293
00628293
@080
00000002
0000000a
80000100
0000000e
80000020
@0ff
00000012

// ==== vlog.f ====
common/fetch_pkg.sv
icache/icache_way.sv
icache/icache_hit_merge.sv
icache/icache_ctrl.sv
ifu/ifu.sv
src/fetch_top.sv
tests/fetch_assert.sv
tests/fetch_tb.sv

// ==== run.sh ====
#!/bin/bash
# Builds and runs the fetch stage testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module fetch_tb \
  -f vlog.f -o fetch_sim > build.log 2>&1 \
  && ./obj_dir/fetch_sim > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "Build or run error"; exit 1; }

cat sim.log
grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

// ==== tests/fetch_tb.sv ====
`timescale 1ns/10ps

module fetch_tb;
  import fetch_pkg::*;

  localparam int mem_words = 128;

  logic            clock;
  logic            reset;
  logic            flush;
  logic [xlen-1:0] dnpc;
  logic            out_ready;
  logic            out_valid;
  logic [xlen-1:0] out_pc;
  logic [xlen-1:0] out_inst;
  logic            mem_req_valid;
  logic            mem_req_ready;
  logic [xlen-1:0] mem_req_addr;
  logic            mem_resp_valid;
  logic [xlen-1:0] mem_resp_data;

  logic [xlen-1:0] pat [256];
  int              req_count [mem_words];
  int              seed;
  int              cycles;
  int              cycle_limit;
  int              accepted;
  int              expected_total;
  int              num_flush;
  int              flush_idx;
  int              stray_requests;
  int              err_first;
  int              err_seq;
  int              err_flush;
  int              tests_passed;
  int              tests_failed;
  int              refill_errors;
  int              mem_delay;
  bit              mem_busy;
  bit              req_seen;
  bit              flush_pending;
  bit              after_flush;
  logic [xlen-1:0] req_addr;
  logic [xlen-1:0] flush_target;
  logic [xlen-1:0] exp_pc;

  fetch_top u_fetch_top (
    .clock          (clock),
    .reset          (reset),
    .flush          (flush),
    .dnpc           (dnpc),
    .out_ready      (out_ready),
    .out_valid      (out_valid),
    .out_pc         (out_pc),
    .out_inst       (out_inst),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_req_addr   (mem_req_addr),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp_data  (mem_resp_data)
  );

  bind fetch_top fetch_assert u_fetch_assert (
    .clock          (clock),
    .reset          (reset),
    .flush          (flush),
    .out_valid      (out_valid),
    .out_ready      (out_ready),
    .out_pc         (out_pc),
    .out_inst       (out_inst),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_req_addr   (mem_req_addr),
    .mem_resp_valid (mem_resp_valid)
  );

  initial clock = 1'b0;
  always #10 clock = ~clock;

  // Image starts at reset_pc.
  function automatic logic [xlen-1:0] mem_word(input logic [xlen-1:0] addr);
    logic [xlen-1:0] idx;
    idx = (addr - reset_pc) >> 2;
    if (idx < mem_words) begin
      return pat[idx];
    end
    return nop_inst;
  endfunction

  function automatic logic [xlen-1:0] predict_next(input logic [xlen-1:0] pc, input inst_u inst);
    logic [xlen-1:0] off_b;
    logic [xlen-1:0] off_j;
    off_b = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11, inst.b.imm10_5,
             inst.b.imm4_1, 1'b0};
    off_j = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12, inst.j.imm11,
             inst.j.imm10_1, 1'b0};
    if (inst.b.opcode == opcode_branch && off_b[xlen-1]) begin
      return pc + off_b;
    end
    if (inst.j.opcode == opcode_jal) begin
      return pc + off_j;
    end
    return pc + 32'd4;
  endfunction

  task automatic compare_pc(input logic [xlen-1:0] expected, input logic [xlen-1:0] actual,
                            output bit ok);
    ok = (actual === expected);
    if (!ok) begin
      $display("FAILED out_pc: expected 0x%08h, got 0x%08h", expected, actual);
    end
  endtask

  task automatic compare_inst(input logic [xlen-1:0] expected, input logic [xlen-1:0] actual,
                              output bit ok);
    ok = (actual === expected);
    if (!ok) begin
      $display("FAILED out_inst: expected 0x%08h, got 0x%08h", expected, actual);
    end
  endtask

  task automatic report_test(input string name, input int errors);
    if (errors == 0) begin
      $display("Test %-20s passed", name);
      tests_passed++;
    end else begin
      $display("Test %-20s failed with %0d errors", name, errors);
      tests_failed++;
    end
  endtask

  task automatic check_transfer();
    logic [xlen-1:0] exp_inst;
    bit              pc_ok;
    bit              inst_ok;
    accepted++;
    exp_inst = mem_word(exp_pc);
    compare_pc(exp_pc, out_pc, pc_ok);
    compare_inst(exp_inst, out_inst, inst_ok);
    if (!(pc_ok && inst_ok)) begin
      if (accepted == 1) err_first++;
      else if (after_flush) err_flush++;
      else err_seq++;
    end
    if (flush_idx < num_flush && accepted == int'(pat[129 + 2 * flush_idx])) begin
      flush_pending = 1'b1;
      flush_target = pat[130 + 2 * flush_idx];
      exp_pc = flush_target;
      after_flush = 1'b1;
      flush_idx++;
    end else begin
      exp_pc = predict_next(exp_pc, exp_inst);
      after_flush = 1'b0;
    end
  endtask

  // Outputs are sampled mid-cycle, where they are stable.
  always @(negedge clock) begin
    if (!reset) begin
      cycles++;
      if (out_valid && out_ready) begin
        check_transfer();
      end
      if (mem_req_valid && mem_req_ready && !mem_busy) begin
        req_seen = 1'b1;
        req_addr = mem_req_addr;
      end
    end
  end

  // Stimulus and memory model.
  always @(posedge clock) begin
    if (!reset) begin
      out_ready <= ($random(seed) % 4) != 0;
      mem_req_ready <= ($random(seed) & 3) != 0;
      mem_resp_valid <= 1'b0;
      flush <= flush_pending;
      if (flush_pending) begin
        dnpc <= flush_target;
        flush_pending = 1'b0;
      end
      if (mem_busy) begin
        mem_delay--;
        if (mem_delay == 0) begin
          mem_resp_valid <= 1'b1;
          mem_resp_data <= mem_word(req_addr);
          mem_busy = 1'b0;
        end
      end else if (req_seen) begin
        req_seen = 1'b0;
        mem_busy = 1'b1;
        mem_delay = 1 + ($random(seed) & 3);
        if (((req_addr - reset_pc) >> 2) < mem_words) begin
          req_count[(req_addr - reset_pc) >> 2]++;
        end else begin
          stray_requests++;
        end
      end
    end
  end

  initial begin
    seed = 1600;
    reset = 1'b1;
    flush = 1'b0;
    dnpc = '0;
    out_ready = 1'b0;
    mem_req_ready = 1'b0;
    mem_resp_valid = 1'b0;
    mem_resp_data = '0;
    for (int i = 0; i < 256; i++) begin
      pat[i] = {i[11:0], 20'h00013};
    end
    $readmemh("tests/fetch_patterns.txt", pat);
    num_flush = int'(pat[128]);
    expected_total = int'(pat[255]);
    cycle_limit = expected_total * 20 + 200;
    exp_pc = reset_pc;
    repeat (16) @(posedge clock);
    reset <= 1'b0;
    while (accepted < expected_total && cycles < cycle_limit) begin
      @(posedge clock);
    end
    repeat (2) @(posedge clock);

    report_test("first_fetch", err_first + ((accepted == 0) ? 1 : 0));
    report_test("predicted_sequence", err_seq);
    if (flush_idx != num_flush) begin
      $display("Only %0d of %0d flushes were issued", flush_idx, num_flush);
    end
    report_test("flush_redirect", err_flush + num_flush - flush_idx);
    for (int i = 0; i < mem_words; i++) begin
      if (req_count[i] > 1) begin
        $display("Address 0x%08h was read from memory %0d times", reset_pc + 4 * i,
                 req_count[i]);
        refill_errors++;
      end
    end
    if (stray_requests != 0) begin
      $display("%0d memory requests fell outside the image", stray_requests);
    end
    report_test("cache_reuse", refill_errors + stray_requests);
    if (accepted < expected_total) begin
      $display("Timeout after %0d cycles with %0d of %0d instructions accepted",
               cycles, accepted, expected_total);
    end
    report_test("transfer_count", (accepted < expected_total) ? 1 : 0);
    $display("Tests: %0d passed, %0d failed", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== tests/fetch_assert.sv ====
`timescale 1ns/10ps

module fetch_assert (
  input logic                        clock,
  input logic                        reset,
  input logic                        flush,
  input logic                        out_valid,
  input logic                        out_ready,
  input logic [fetch_pkg::xlen-1:0]  out_pc,
  input logic [fetch_pkg::xlen-1:0]  out_inst,
  input logic                        mem_req_valid,
  input logic                        mem_req_ready,
  input logic [fetch_pkg::xlen-1:0]  mem_req_addr,
  input logic                        mem_resp_valid
);
  import fetch_pkg::*;

  logic outstanding;

  // One read in flight between accept and response.
  always_ff @(posedge clock) begin
    if (reset) begin
      outstanding <= 1'b0;
    end else if (mem_req_valid && mem_req_ready) begin
      outstanding <= 1'b1;
    end else if (mem_resp_valid) begin
      outstanding <= 1'b0;
    end
  end

  a_out_stable: assert property (@(posedge clock) disable iff (reset)
    out_valid && !out_ready |=> $stable(out_pc) && $stable(out_inst))
    else $error("fetch output changed while stalled");

  a_req_hold: assert property (@(posedge clock) disable iff (reset)
    mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_addr))
    else $error("memory request dropped before ready");

  a_one_outstanding: assert property (@(posedge clock) disable iff (reset)
    outstanding |-> !mem_req_valid)
    else $error("second memory request while one is outstanding");

  a_no_xfer_on_flush: assert property (@(posedge clock) disable iff (reset)
    flush |=> !out_valid)
    else $error("fetch output valid in the cycle after a flush");

endmodule

// ==== src/fetch_top.sv ====
`timescale 1ns/10ps

module fetch_top (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        flush,
  input  logic [fetch_pkg::xlen-1:0]  dnpc,
  input  logic                        out_ready,
  output logic                        out_valid,
  output logic [fetch_pkg::xlen-1:0]  out_pc,
  output logic [fetch_pkg::xlen-1:0]  out_inst,
  output logic                        mem_req_valid,
  input  logic                        mem_req_ready,
  output logic [fetch_pkg::xlen-1:0]  mem_req_addr,
  input  logic                        mem_resp_valid,
  input  logic [fetch_pkg::xlen-1:0]  mem_resp_data
);
  import fetch_pkg::*;

  logic [xlen-1:0]       cache_addr;
  logic [xlen-1:0]       cache_inst;
  logic                  hit;
  logic [index_bits-1:0] index;
  logic [tag_bits-1:0]   wr_tag;
  logic [xlen-1:0]       wr_data;
  logic [num_ways-1:0]   way_write;
  logic [num_ways-1:0]   way_hit;
  logic [xlen-1:0]       way_data [num_ways];

  ifu u_ifu (
    .clock      (clock),
    .reset      (reset),
    .flush      (flush),
    .dnpc       (dnpc),
    .out_ready  (out_ready),
    .out_valid  (out_valid),
    .out_pc     (out_pc),
    .out_inst   (out_inst),
    .cache_addr (cache_addr),
    .hit        (hit),
    .cache_inst (cache_inst)
  );

  icache_ctrl u_icache_ctrl (
    .clock          (clock),
    .reset          (reset),
    .cache_addr     (cache_addr),
    .hit            (hit),
    .index          (index),
    .wr_tag         (wr_tag),
    .wr_data        (wr_data),
    .way_write      (way_write),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_req_addr   (mem_req_addr),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp_data  (mem_resp_data)
  );

  for (genvar g = 0; g < num_ways; g++) begin : g_way
    icache_way u_icache_way (
      .clock      (clock),
      .reset      (reset),
      .index      (index),
      .lookup_tag (cache_addr[xlen-1 -: tag_bits]),
      .way_write  (way_write[g]),
      .wr_tag     (wr_tag),
      .wr_data    (wr_data),
      .way_hit    (way_hit[g]),
      .way_data   (way_data[g])
    );
  end

  icache_hit_merge u_icache_hit_merge (
    .way_hit    (way_hit),
    .way_data   (way_data),
    .hit        (hit),
    .cache_inst (cache_inst)
  );

endmodule

// ==== ifu/ifu.sv ====
`timescale 1ns/10ps

module ifu (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        flush,
  input  logic [fetch_pkg::xlen-1:0]  dnpc,
  input  logic                        out_ready,
  output logic                        out_valid,
  output logic [fetch_pkg::xlen-1:0]  out_pc,
  output logic [fetch_pkg::xlen-1:0]  out_inst,
  output logic [fetch_pkg::xlen-1:0]  cache_addr,
  input  logic                        hit,
  input  logic [fetch_pkg::xlen-1:0]  cache_inst
);
  import fetch_pkg::*;

  typedef enum logic {
    st_wait = 1'b0,
    st_hold = 1'b1
  } state_t;

  state_t          state;
  state_t          state_next;
  logic [xlen-1:0] pc;
  logic [xlen-1:0] pc_next;
  inst_u           inst;
  inst_u           inst_next;
  logic            flush_r;
  logic            flush_r_next;
  logic [xlen-1:0] dnpc_r;
  logic [xlen-1:0] dnpc_r_next;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_j;
  logic [xlen-1:0] pc_incr;
  logic            is_back_branch;
  logic            is_jal;
  logic            advance;

  // Static prediction from the held instruction.
  assign imm_b = {{20{inst.b.imm12}}, inst.b.imm11, inst.b.imm10_5, inst.b.imm4_1, 1'b0};
  assign imm_j = {{12{inst.j.imm20}}, inst.j.imm19_12, inst.j.imm11, inst.j.imm10_1, 1'b0};

  assign is_back_branch = (inst.b.opcode == opcode_branch) && inst.b.imm12;
  assign is_jal = (inst.j.opcode == opcode_jal);

  always_comb begin
    if (is_back_branch) begin
      pc_incr = imm_b;
    end else if (is_jal) begin
      pc_incr = imm_j;
    end else begin
      pc_incr = 32'd4;
    end
  end

  assign advance = (out_valid && out_ready) || flush || flush_r;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_wait;
      pc <= reset_pc;
      inst <= nop_inst;
      flush_r <= 1'b0;
    end else begin
      state <= state_next;
      pc <= pc_next;
      inst <= inst_next;
      flush_r <= flush_r_next;
    end
  end

  always_ff @(posedge clock) begin
    dnpc_r <= dnpc_r_next;
  end

  always_comb begin
    state_next = state;
    pc_next = pc;
    inst_next = inst;
    flush_r_next = flush_r;
    dnpc_r_next = dnpc_r;
    if (state == st_hold) begin
      if (advance) begin
        // A live flush wins over a stored one.
        if (flush) begin
          pc_next = dnpc;
        end else if (flush_r) begin
          pc_next = dnpc_r;
        end else begin
          pc_next = pc + pc_incr;
        end
        flush_r_next = 1'b0;
        // A live flush always passes through wait.
        if (hit && !flush) begin
          inst_next = cache_inst;
        end else begin
          state_next = st_wait;
        end
      end
    end else begin
      // A flush here is applied after the refill.
      if (flush) begin
        flush_r_next = 1'b1;
        dnpc_r_next = dnpc;
      end
      if (hit) begin
        state_next = st_hold;
        inst_next = cache_inst;
      end
    end
  end

  assign cache_addr = (state == st_hold) ? pc_next : pc;
  assign out_valid = (state == st_hold) && !flush && !flush_r;
  assign out_pc = pc;
  assign out_inst = inst;

endmodule

// ==== icache/icache_ctrl.sv ====
`timescale 1ns/10ps

module icache_ctrl (
  input  logic                              clock,
  input  logic                              reset,
  input  logic [fetch_pkg::xlen-1:0]        cache_addr,
  input  logic                              hit,
  output logic [fetch_pkg::index_bits-1:0]  index,
  output logic [fetch_pkg::tag_bits-1:0]    wr_tag,
  output logic [fetch_pkg::xlen-1:0]        wr_data,
  output logic [fetch_pkg::num_ways-1:0]    way_write,
  output logic                              mem_req_valid,
  input  logic                              mem_req_ready,
  output logic [fetch_pkg::xlen-1:0]        mem_req_addr,
  input  logic                              mem_resp_valid,
  input  logic [fetch_pkg::xlen-1:0]        mem_resp_data
);
  import fetch_pkg::*;

  typedef enum logic [1:0] {
    ctrl_idle,
    ctrl_request,
    ctrl_wait
  } state_t;

  state_t                state;
  logic [xlen-1:0]       miss_addr;
  logic [index_bits-1:0] miss_index;
  logic [num_sets-1:0]   victim;
  logic                  refill_done;

  assign miss_index = miss_addr[index_bits+1:2];
  assign refill_done = (state == ctrl_wait) && mem_resp_valid;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= ctrl_idle;
      victim <= '0;
    end else begin
      case (state)
        ctrl_idle: if (!hit) state <= ctrl_request;
        ctrl_request: if (mem_req_ready) state <= ctrl_wait;
        ctrl_wait: begin
          if (mem_resp_valid) begin
            state <= ctrl_idle;
            victim[miss_index] <= ~victim[miss_index];
          end
        end
        default: state <= ctrl_idle;
      endcase
    end
  end

  // Miss address is captured once, in idle.
  always_ff @(posedge clock) begin
    if (state == ctrl_idle && !hit) begin
      miss_addr <= cache_addr;
    end
  end

  assign index = (state == ctrl_idle) ? cache_addr[index_bits+1:2] : miss_index;
  assign wr_tag = miss_addr[xlen-1 -: tag_bits];
  assign wr_data = mem_resp_data;
  assign way_write = refill_done ? (num_ways'(1) << victim[miss_index]) : '0;

  assign mem_req_valid = (state == ctrl_request);
  assign mem_req_addr = {miss_addr[xlen-1:2], 2'b00};

endmodule

// ==== icache/icache_hit_merge.sv ====
`timescale 1ns/10ps

module icache_hit_merge (
  input  logic [fetch_pkg::num_ways-1:0]  way_hit,
  input  logic [fetch_pkg::xlen-1:0]      way_data [fetch_pkg::num_ways],
  output logic                            hit,
  output logic [fetch_pkg::xlen-1:0]      cache_inst
);
  import fetch_pkg::*;

  assign hit = |way_hit;

  // One-hot mux. A refill only fills a line that missed in every
  // way, so at most one way hits.
  always_comb begin
    cache_inst = '0;
    for (int w = 0; w < num_ways; w++) begin
      cache_inst = cache_inst | ({xlen{way_hit[w]}} & way_data[w]);
    end
  end

endmodule

// ==== icache/icache_way.sv ====
`timescale 1ns/10ps

module icache_way (
  input  logic                              clock,
  input  logic                              reset,
  input  logic [fetch_pkg::index_bits-1:0]  index,
  input  logic [fetch_pkg::tag_bits-1:0]    lookup_tag,
  input  logic                              way_write,
  input  logic [fetch_pkg::tag_bits-1:0]    wr_tag,
  input  logic [fetch_pkg::xlen-1:0]        wr_data,
  output logic                              way_hit,
  output logic [fetch_pkg::xlen-1:0]        way_data
);
  import fetch_pkg::*;

  logic [num_sets-1:0] valid;
  logic [tag_bits-1:0] tag_mem [num_sets];
  logic [xlen-1:0]     data_mem [num_sets];

  always_ff @(posedge clock) begin
    if (reset) begin
      valid <= '0;
    end else if (way_write) begin
      valid[index] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (way_write) begin
      tag_mem[index] <= wr_tag;
      data_mem[index] <= wr_data;
    end
  end

  // Asynchronous read.
  assign way_hit = valid[index] && (tag_mem[index] == lookup_tag);
  assign way_data = data_mem[index];

endmodule

// ==== common/fetch_pkg.sv ====
package fetch_pkg;

  // Datapath sizes.
  localparam int xlen = 32;

  localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

  // addi x0, x0, 0
  localparam logic [xlen-1:0] nop_inst = 32'h0000_0013;

  // Cache geometry, one word per line.
  localparam int num_ways = 2;
  localparam int num_sets = 16;
  localparam int index_bits = 4;
  localparam int tag_bits = xlen - index_bits - 2;

  localparam logic [6:0] opcode_branch = 7'b110_0011;
  localparam logic [6:0] opcode_jal = 7'b110_1111;

  // Conditional branch layout.
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } inst_b_t;

  // Jump and link layout.
  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } inst_j_t;

  // Same word, read as either format by the predictor.
  typedef union packed {
    inst_b_t b;
    inst_j_t j;
  } inst_u;

endpackage
